// ==== compile.f ====
+incdir+source
source/axis_pkg.sv
source/axis_register.sv
source/axis_splitter.sv
source/axis_realign.sv
source/axis_split_top.sv
sim/tb_axis_split.sv

// ==== Makefile ====
# Verilator build and run of the AXI4-Stream split testbench

SRCS := compile.f $(wildcard source/*.sv source/*.svh sim/*.sv)
BIN  := obj_dir/Vtb_axis_split

.PHONY: all run clean

all: run

# Rebuilt only when a source file or the file list changes
$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_split \
		-f compile.f -o Vtb_axis_split

# Passes only if the simulation prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf obj_dir

// ==== sim/tb_axis_split.sv ====
// Random packets of 1 to 20 bytes with a fixed seed and checks that rely on the defs header
`timescale 1ns/100ps
`include "axis_defs.svh"

// Compares one output stream against the expected word that the testbench keeps at its queue head
module stream_check #(
	parameter string NAME = "stream"
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 tvalid,
	input  logic                 tready,
	input  axis_pkg::axis_data_t tdata,
	input  axis_pkg::axis_keep_t tkeep,
	input  axis_pkg::axis_user_t tuser,
	input  logic                 tlast,
	input  logic                 exp_have,
	input  axis_pkg::axis_data_t exp_data,
	input  axis_pkg::axis_keep_t exp_keep,
	input  axis_pkg::axis_user_t exp_user,
	input  logic                 exp_last,
	output int                   value_errors,
	output int                   other_errors
);
	import axis_pkg::*;

	// Lanes outside the expected keep carry don't-care data
	axis_data_t data_mask;

	initial begin
		value_errors = 0;
		other_errors = 0;
	end

	always_comb begin
		for (int b = 0; b < `AXIS_BYTES; b++) begin
			data_mask[8*b +: 8] = {8{exp_keep[b]}};
		end
	end

	task automatic report_mismatch(input string sig, input axis_data_t expected,
			input axis_data_t actual);
		value_errors++;
		$display("CHECK FAILED time=%0t signal=%s_%s expected=%h actual=%h",
			$time, NAME, sig, expected, actual);
	endtask

	task automatic report_problem(input string what);
		other_errors++;
		$display("Error at %0t on %s: %s", $time, NAME, what);
	endtask

	// A word with nothing left in the reference queue is a duplicate or a stray
	a_word_expected: assert property (@(posedge clk) disable iff (!rst_n)
		tvalid |-> exp_have)
		else report_problem("a word arrived that no sent packet accounts for");

	a_keep: assert property (@(posedge clk) disable iff (!rst_n)
		tvalid && exp_have |-> tkeep == exp_keep)
		else report_mismatch("tkeep", axis_data_t'(exp_keep), axis_data_t'($sampled(tkeep)));

	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		tvalid && exp_have |-> (tdata & data_mask) == exp_data)
		else report_mismatch("tdata", exp_data, $sampled(tdata) & data_mask);

	a_user: assert property (@(posedge clk) disable iff (!rst_n)
		tvalid && exp_have |-> tuser == exp_user)
		else report_mismatch("tuser", axis_data_t'(exp_user), axis_data_t'($sampled(tuser)));

	a_last: assert property (@(posedge clk) disable iff (!rst_n)
		tvalid && exp_have |-> tlast == exp_last)
		else report_mismatch("tlast", axis_data_t'(exp_last), axis_data_t'($sampled(tlast)));

	// Back-pressure must hold the word unchanged until it is taken
	a_stable: assert property (@(posedge clk) disable iff (!rst_n)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) &&
			$stable(tuser) && $stable(tlast))
		else report_problem("the word changed or vanished while stalled");

endmodule

module tb_axis_split;
	import axis_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_PKTS     = 60;
	localparam int MAX_LEN      = 20;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_PKTS * 20 * 4) * CLK_PERIOD;
	localparam int CNT_BITS     = $clog2(`AXIS_BYTES + 1);
	localparam logic [31:0] SEED = 32'hfe74;

	// One reference byte, with the tuser of its input word and a flag on the last byte of its stream
	typedef struct packed {
		logic       last;
		axis_user_t user;
		logic [7:0] data;
	} ref_byte_t;

	// The next word that an output should present
	typedef struct packed {
		logic [CNT_BITS-1:0] count;
		logic                last;
		axis_user_t          user;
		axis_keep_t          keep;
		axis_data_t          data;
	} exp_word_t;

	logic       clk;
	logic       rst_n;
	logic       axis_i_tvalid;
	logic       axis_i_tready;
	axis_data_t axis_i_tdata;
	axis_keep_t axis_i_tkeep;
	axis_user_t axis_i_tuser;
	logic       axis_i_tlast;
	logic       axis_o1_tvalid;
	logic       axis_o1_tready;
	axis_data_t axis_o1_tdata;
	axis_keep_t axis_o1_tkeep;
	axis_user_t axis_o1_tuser;
	logic       axis_o1_tlast;
	logic       axis_o2_tvalid;
	logic       axis_o2_tready;
	axis_data_t axis_o2_tdata;
	axis_keep_t axis_o2_tkeep;
	axis_user_t axis_o2_tuser;
	logic       axis_o2_tlast;

	// Header bytes and payload bytes still owed by the DUT, oldest first
	ref_byte_t hdr_q[$];
	ref_byte_t pay_q[$];
	exp_word_t exp1;
	exp_word_t exp2;
	logic      pop1;
	logic      pop2;
	int        cycle;
	int        local_errors;
	int        o1_value_errors;
	int        o1_other_errors;
	int        o2_value_errors;
	int        o2_other_errors;

	axis_split_top dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.axis_i_tvalid  (axis_i_tvalid),
		.axis_i_tready  (axis_i_tready),
		.axis_i_tdata   (axis_i_tdata),
		.axis_i_tkeep   (axis_i_tkeep),
		.axis_i_tuser   (axis_i_tuser),
		.axis_i_tlast   (axis_i_tlast),
		.axis_o1_tvalid (axis_o1_tvalid),
		.axis_o1_tready (axis_o1_tready),
		.axis_o1_tdata  (axis_o1_tdata),
		.axis_o1_tkeep  (axis_o1_tkeep),
		.axis_o1_tuser  (axis_o1_tuser),
		.axis_o1_tlast  (axis_o1_tlast),
		.axis_o2_tvalid (axis_o2_tvalid),
		.axis_o2_tready (axis_o2_tready),
		.axis_o2_tdata  (axis_o2_tdata),
		.axis_o2_tkeep  (axis_o2_tkeep),
		.axis_o2_tuser  (axis_o2_tuser),
		.axis_o2_tlast  (axis_o2_tlast)
	);

	stream_check #(.NAME("axis_o1")) o1_check (
		.clk (clk), .rst_n (rst_n),
		.tvalid (axis_o1_tvalid), .tready (axis_o1_tready), .tdata (axis_o1_tdata),
		.tkeep (axis_o1_tkeep), .tuser (axis_o1_tuser), .tlast (axis_o1_tlast),
		.exp_have (exp1.count != 0), .exp_data (exp1.data), .exp_keep (exp1.keep),
		.exp_user (exp1.user), .exp_last (exp1.last),
		.value_errors (o1_value_errors), .other_errors (o1_other_errors)
	);

	stream_check #(.NAME("axis_o2")) o2_check (
		.clk (clk), .rst_n (rst_n),
		.tvalid (axis_o2_tvalid), .tready (axis_o2_tready), .tdata (axis_o2_tdata),
		.tkeep (axis_o2_tkeep), .tuser (axis_o2_tuser), .tlast (axis_o2_tlast),
		.exp_have (exp2.count != 0), .exp_data (exp2.data), .exp_keep (exp2.keep),
		.exp_user (exp2.user), .exp_last (exp2.last),
		.value_errors (o2_value_errors), .other_errors (o2_other_errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Packs bytes from the queue head into lane 0 upwards until the word is full or a stream ends
	function automatic exp_word_t build_word(input ref_byte_t q[$]);
		exp_word_t w;
		int n;
		logic done;
		w = '0;
		n = 0;
		done = 1'b0;
		if (q.size() > 0) begin
			w.user = q[0].user;
		end
		while (!done && n < `AXIS_BYTES && n < q.size()) begin
			w.data[8*n +: 8] = q[n].data;
			w.keep[n] = 1'b1;
			w.last = q[n].last;
			done = q[n].last;
			n++;
		end
		w.count = CNT_BITS'(n);
		return w;
	endfunction

	// Outputs and readies are settled at the falling edge, so the transfer at the next rising
	// edge is known here and the expected word is updated well away from it
	always @(negedge clk) begin
		if (pop1) begin
			repeat (exp1.count) void'(hdr_q.pop_front());
		end
		if (pop2) begin
			repeat (exp2.count) void'(pay_q.pop_front());
		end
		exp1 = build_word(hdr_q);
		exp2 = build_word(pay_q);
		pop1 = rst_n && axis_o1_tvalid && axis_o1_tready && (exp1.count != 0);
		pop2 = rst_n && axis_o2_tvalid && axis_o2_tready && (exp2.count != 0);
	end

	// The first edge is skipped since the registers only clear on it
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n && cycle > 0 |-> !axis_o1_tvalid && !axis_o2_tvalid && !axis_i_tready)
		else begin
			local_errors++;
			$display("Error at %0t: a valid or the input ready was high during reset", $time);
		end

	// Input ready comes up one cycle after the first edge that sees reset released
	a_reset_release: assert property (@(posedge clk)
		$rose(rst_n) |-> !axis_o1_tvalid && !axis_o2_tvalid ##1 axis_i_tready)
		else begin
			local_errors++;
			$display("Error at %0t: wrong valid or input ready right after reset release",
				$time);
		end

	// Each output stalls about a third of the time, independently of the other
	task automatic drive_backpressure();
		forever begin
			@(posedge clk);
			#DRIVE_DELAY;
			axis_o1_tready = ($urandom_range(2, 0) != 0);
			axis_o2_tready = ($urandom_range(2, 0) != 0);
		end
	endtask

	// Entered and left 2 ns after a rising edge
	task automatic send_packet(input int len);
		logic [7:0] pkt[$];
		axis_user_t users[$];
		ref_byte_t rb;
		axis_data_t d;
		axis_keep_t k;
		int nwords;
		int hdr_len;
		int idx;
		int i;
		int w;
		int b;
		logic ready_now;
		nwords = (len + `AXIS_BYTES - 1) / `AXIS_BYTES;
		hdr_len = (len < `AXIS_SPLIT_INDEX) ? len : `AXIS_SPLIT_INDEX;
		for (w = 0; w < nwords; w++) begin
			users.push_back(axis_user_t'($urandom));
		end
		// The reference queues get the bytes before the first word goes out
		for (i = 0; i < len; i++) begin
			pkt.push_back(8'($urandom));
			rb.data = pkt[i];
			rb.user = users[i / `AXIS_BYTES];
			if (i < hdr_len) begin
				rb.last = (i == hdr_len - 1);
				hdr_q.push_back(rb);
			end else begin
				rb.last = (i == len - 1);
				pay_q.push_back(rb);
			end
		end
		for (w = 0; w < nwords; w++) begin
			if ($urandom_range(3, 0) == 0) begin
				axis_i_tvalid = 1'b0;
				repeat ($urandom_range(3, 1)) @(posedge clk);
				#DRIVE_DELAY;
			end
			// Lanes past the packet end get junk so masking is exercised
			k = '0;
			for (b = 0; b < `AXIS_BYTES; b++) begin
				idx = w * `AXIS_BYTES + b;
				if (idx < len) begin
					d[8*b +: 8] = pkt[idx];
					k[b] = 1'b1;
				end else begin
					d[8*b +: 8] = 8'($urandom);
				end
			end
			axis_i_tvalid = 1'b1;
			axis_i_tdata  = d;
			axis_i_tkeep  = k;
			axis_i_tuser  = users[w];
			axis_i_tlast  = (w == nwords - 1);
			do begin
				@(negedge clk);
				ready_now = axis_i_tready;
				@(posedge clk);
			end while (!ready_now);
			#DRIVE_DELAY;
		end
	endtask

	task automatic close_run();
		int value_total;
		int other_total;
		value_total = o1_value_errors + o2_value_errors;
		other_total = o1_other_errors + o2_other_errors + local_errors;
		$display("Error counts: %0d value mismatches, %0d other failures",
			value_total, other_total);
		if (value_total == 0 && other_total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// Budget of 20 words of 4 cycles for every packet, plus reset
	initial begin
		#(TIMEOUT_NS);
		local_errors++;
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		close_run();
	end

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b0;
		axis_i_tvalid = 1'b0;
		axis_i_tdata = '0;
		axis_i_tkeep = '0;
		axis_i_tuser = '0;
		axis_i_tlast = 1'b0;
		axis_o1_tready = 1'b0;
		axis_o2_tready = 1'b0;
		cycle = 0;
		local_errors = 0;
		exp1 = '0;
		exp2 = '0;
		pop1 = 1'b0;
		pop2 = 1'b0;
		fork
			drive_backpressure();
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		for (int p = 0; p < NUM_PKTS; p++) begin
			send_packet(int'($urandom_range(MAX_LEN, 1)));
		end
		axis_i_tvalid = 1'b0;
		// Lost bytes keep a queue from draining, which the watchdog then reports
		while (hdr_q.size() != 0 || pay_q.size() != 0) begin
			@(negedge clk);
		end
		// A few more cycles catch any stray or duplicated word
		repeat (8) @(posedge clk);
		close_run();
	end

endmodule

// ==== source/axis_split_top.sv ====
// Split position comes from AXIS_SPLIT_INDEX and the input stream must arrive packed
`timescale 1ns/100ps
`include "axis_defs.svh"

module axis_split_top (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 axis_i_tvalid,
	output logic                 axis_i_tready,
	input  axis_pkg::axis_data_t axis_i_tdata,
	input  axis_pkg::axis_keep_t axis_i_tkeep,
	input  axis_pkg::axis_user_t axis_i_tuser,
	input  logic                 axis_i_tlast,

	output logic                 axis_o1_tvalid,
	input  logic                 axis_o1_tready,
	output axis_pkg::axis_data_t axis_o1_tdata,
	output axis_pkg::axis_keep_t axis_o1_tkeep,
	output axis_pkg::axis_user_t axis_o1_tuser,
	output logic                 axis_o1_tlast,

	output logic                 axis_o2_tvalid,
	input  logic                 axis_o2_tready,
	output axis_pkg::axis_data_t axis_o2_tdata,
	output axis_pkg::axis_keep_t axis_o2_tkeep,
	output axis_pkg::axis_user_t axis_o2_tuser,
	output logic                 axis_o2_tlast
);
	import axis_pkg::*;

	// Payload before realignment, still in the lanes it had in the input packet
	logic       split_o2_tvalid;
	logic       split_o2_tready;
	axis_data_t split_o2_tdata;
	axis_keep_t split_o2_tkeep;
	axis_user_t split_o2_tuser;
	logic       split_o2_tlast;

	// The header output goes straight out of the splitter
	axis_splitter #(
		.SPLIT_BYTE_INDEX (`AXIS_SPLIT_INDEX)
	) u_splitter (
		.clk            (clk),
		.rst_n          (rst_n),
		.axis_i_tvalid  (axis_i_tvalid),
		.axis_i_tready  (axis_i_tready),
		.axis_i_tdata   (axis_i_tdata),
		.axis_i_tkeep   (axis_i_tkeep),
		.axis_i_tuser   (axis_i_tuser),
		.axis_i_tlast   (axis_i_tlast),
		.axis_o1_tvalid (axis_o1_tvalid),
		.axis_o1_tready (axis_o1_tready),
		.axis_o1_tdata  (axis_o1_tdata),
		.axis_o1_tkeep  (axis_o1_tkeep),
		.axis_o1_tuser  (axis_o1_tuser),
		.axis_o1_tlast  (axis_o1_tlast),
		.axis_o2_tvalid (split_o2_tvalid),
		.axis_o2_tready (split_o2_tready),
		.axis_o2_tdata  (split_o2_tdata),
		.axis_o2_tkeep  (split_o2_tkeep),
		.axis_o2_tuser  (split_o2_tuser),
		.axis_o2_tlast  (split_o2_tlast)
	);

	// Payload starts at the lane where the split index falls in its word
	axis_realign #(
		.SHIFT (`AXIS_SPLIT_INDEX % `AXIS_BYTES)
	) u_realign (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_tvalid  (split_o2_tvalid),
		.in_tready  (split_o2_tready),
		.in_tdata   (split_o2_tdata),
		.in_tkeep   (split_o2_tkeep),
		.in_tuser   (split_o2_tuser),
		.in_tlast   (split_o2_tlast),
		.out_tvalid (axis_o2_tvalid),
		.out_tready (axis_o2_tready),
		.out_tdata  (axis_o2_tdata),
		.out_tkeep  (axis_o2_tkeep),
		.out_tuser  (axis_o2_tuser),
		.out_tlast  (axis_o2_tlast)
	);

endmodule

// ==== source/axis_realign.sv ====
// Input packets must start at lane SHIFT and be packed after their first word, and SHIFT is fixed
`timescale 1ns/100ps
`include "axis_defs.svh"

module axis_realign #(
	parameter int SHIFT = 0
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 in_tvalid,
	output logic                 in_tready,
	input  axis_pkg::axis_data_t in_tdata,
	input  axis_pkg::axis_keep_t in_tkeep,
	input  axis_pkg::axis_user_t in_tuser,
	input  logic                 in_tlast,

	output logic                 out_tvalid,
	input  logic                 out_tready,
	output axis_pkg::axis_data_t out_tdata,
	output axis_pkg::axis_keep_t out_tkeep,
	output axis_pkg::axis_user_t out_tuser,
	output logic                 out_tlast
);
	import axis_pkg::*;

	// Lanes of the output word that the residue fills
	localparam int RES_LANES = `AXIS_BYTES - SHIFT;

	realign_state_t state;
	realign_state_t nxt_state;

	// Residue holds the high lanes of the previous word, already moved down to lane 0
	axis_data_t res_tdata;
	axis_keep_t res_tkeep;
	axis_user_t res_tuser;

	axis_data_t in_shift_data;
	axis_keep_t in_shift_keep;
	logic       out_free;
	logic       in_fire;
	logic       emit;
	axis_data_t emit_data;
	axis_keep_t emit_keep;
	axis_user_t emit_user;
	logic       emit_last;

	assign out_free = !out_tvalid || out_tready;
	// The flush cycle owns the output so no input is taken then
	assign in_tready = out_free && (state != RA_FLUSH);
	assign in_fire = in_tvalid && in_tready;

	assign in_shift_data = in_tdata >> (8 * SHIFT);
	assign in_shift_keep = in_tkeep >> SHIFT;

	always_comb begin
		nxt_state = state;
		emit      = 1'b0;
		emit_data = res_tdata;
		emit_keep = res_tkeep;
		emit_user = res_tuser;
		emit_last = 1'b0;
		case (state)
			RA_FIRST: begin
				// A one-word packet or a zero shift completes the output word at once
				if (in_fire) begin
					if (in_tlast || (SHIFT == 0)) begin
						emit      = 1'b1;
						emit_data = in_shift_data;
						emit_keep = in_shift_keep;
						emit_user = in_tuser;
						emit_last = in_tlast;
					end else begin
						nxt_state = RA_MID;
					end
				end
			end
			RA_MID: begin
				// Low lanes of the new word top up the residue
				if (in_fire) begin
					emit      = 1'b1;
					emit_data = res_tdata | (in_tdata << (8 * RES_LANES));
					emit_keep = res_tkeep | (in_tkeep << RES_LANES);
					if (in_tlast) begin
						if (in_shift_keep != '0) begin
							nxt_state = RA_FLUSH;
						end else begin
							emit_last = 1'b1;
							nxt_state = RA_FIRST;
						end
					end
				end
			end
			RA_FLUSH: begin
				// The tail of the packet is whatever residue is left
				if (out_free) begin
					emit      = 1'b1;
					emit_last = 1'b1;
					nxt_state = RA_FIRST;
				end
			end
			default: begin
				nxt_state = RA_FIRST;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= RA_FIRST;
			out_tvalid <= 1'b0;
		end else begin
			state <= nxt_state;
			if (out_free) begin
				out_tvalid <= emit;
			end
		end
	end

	// every accepted word leaves its high lanes behind as the next residue
	always_ff @(posedge clk) begin
		if (in_fire) begin
			res_tdata <= in_shift_data;
			res_tkeep <= in_shift_keep;
			res_tuser <= in_tuser;
		end
		if (emit) begin
			out_tdata <= emit_data;
			out_tkeep <= emit_keep;
			out_tuser <= emit_user;
			out_tlast <= emit_last;
		end
	end

	// Realigned words must be filled from lane 0 with no gaps
	a_out_packed: assert property (@(posedge clk) disable iff (!rst_n)
		out_tvalid |-> (out_tkeep != '0) && (((out_tkeep + 1'b1) & out_tkeep) == '0))
		else $error("axis_realign output tkeep is not contiguous from lane 0");

endmodule

// ==== source/axis_splitter.sv ====
// Input tkeep must be packed and SPLIT_BYTE_INDEX at least one, and o2 is unaligned for uneven splits
`timescale 1ns/100ps
`include "axis_defs.svh"

module axis_splitter #(
	parameter int SPLIT_BYTE_INDEX = 1
) (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 axis_i_tvalid,
	output logic                 axis_i_tready,
	input  axis_pkg::axis_data_t axis_i_tdata,
	input  axis_pkg::axis_keep_t axis_i_tkeep,
	input  axis_pkg::axis_user_t axis_i_tuser,
	input  logic                 axis_i_tlast,

	output logic                 axis_o1_tvalid,
	input  logic                 axis_o1_tready,
	output axis_pkg::axis_data_t axis_o1_tdata,
	output axis_pkg::axis_keep_t axis_o1_tkeep,
	output axis_pkg::axis_user_t axis_o1_tuser,
	output logic                 axis_o1_tlast,

	output logic                 axis_o2_tvalid,
	input  logic                 axis_o2_tready,
	output axis_pkg::axis_data_t axis_o2_tdata,
	output axis_pkg::axis_keep_t axis_o2_tkeep,
	output axis_pkg::axis_user_t axis_o2_tuser,
	output logic                 axis_o2_tlast
);
	import axis_pkg::*;

	// Word that holds byte SPLIT_BYTE_INDEX, shared by both outputs unless the split is even
	localparam word_ctr_t SPLIT_WORD = word_ctr_t'(SPLIT_BYTE_INDEX / `AXIS_BYTES);
	// Word that holds the final header byte
	localparam word_ctr_t LAST_HDR_WORD = word_ctr_t'((SPLIT_BYTE_INDEX - 1) / `AXIS_BYTES);
	localparam int SPLIT_REM = SPLIT_BYTE_INDEX % `AXIS_BYTES;
	// Header lanes of the boundary word, empty when the split falls on a word edge
	localparam axis_keep_t O1_SPLIT_MASK = axis_keep_t'((1 << SPLIT_REM) - 1);

	word_ctr_t  ctr;
	axis_keep_t o1_keep;
	axis_keep_t o2_keep;
	logic       o1_ready;
	logic       o2_ready;
	logic       in_fire;

	// Both stages must have room since one input word may feed both
	assign axis_i_tready = o1_ready && o2_ready;
	assign in_fire = axis_i_tvalid && axis_i_tready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctr <= '0;
		end else if (in_fire) begin
			if (axis_i_tlast) begin
				ctr <= '0;
			end else if (ctr != '1) begin
				ctr <= ctr + 1'b1;
			end
		end
	end

	// Steer each lane by word position relative to the boundary word
	always_comb begin
		o1_keep = '0;
		o2_keep = '0;
		if (ctr < SPLIT_WORD) begin
			o1_keep = axis_i_tkeep;
		end else if (ctr == SPLIT_WORD) begin
			o1_keep = axis_i_tkeep & O1_SPLIT_MASK;
			o2_keep = axis_i_tkeep & ~O1_SPLIT_MASK;
		end else begin
			o2_keep = axis_i_tkeep;
		end
	end

	// A word with no lanes for an output is simply not offered to it
	axis_register o1_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_tvalid  (in_fire && (|o1_keep)),
		.in_tready  (o1_ready),
		.in_tdata   (axis_i_tdata),
		.in_tkeep   (o1_keep),
		.in_tuser   (axis_i_tuser),
		.in_tlast   (axis_i_tlast || (ctr == LAST_HDR_WORD)),
		.out_tvalid (axis_o1_tvalid),
		.out_tready (axis_o1_tready),
		.out_tdata  (axis_o1_tdata),
		.out_tkeep  (axis_o1_tkeep),
		.out_tuser  (axis_o1_tuser),
		.out_tlast  (axis_o1_tlast)
	);

	// Data stays in its original lanes here
	axis_register o2_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_tvalid  (in_fire && (|o2_keep)),
		.in_tready  (o2_ready),
		.in_tdata   (axis_i_tdata),
		.in_tkeep   (o2_keep),
		.in_tuser   (axis_i_tuser),
		.in_tlast   (axis_i_tlast),
		.out_tvalid (axis_o2_tvalid),
		.out_tready (axis_o2_tready),
		.out_tdata  (axis_o2_tdata),
		.out_tkeep  (axis_o2_tkeep),
		.out_tuser  (axis_o2_tuser),
		.out_tlast  (axis_o2_tlast)
	);

	// Inner words are full and a last word is filled from lane 0 upwards
	a_in_packed: assert property (@(posedge clk) disable iff (!rst_n)
		axis_i_tvalid |-> (axis_i_tlast ?
			((axis_i_tkeep != '0) && (((axis_i_tkeep + 1'b1) & axis_i_tkeep) == '0)) :
			(axis_i_tkeep == '1)))
		else $error("axis_splitter input tkeep is not packed");

endmodule

// ==== source/axis_register.sv ====
// Registered ready with two entries so one word of skid is absorbed and throughput is full
`timescale 1ns/100ps
`include "axis_defs.svh"

module axis_register (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 in_tvalid,
	output logic                 in_tready,
	input  axis_pkg::axis_data_t in_tdata,
	input  axis_pkg::axis_keep_t in_tkeep,
	input  axis_pkg::axis_user_t in_tuser,
	input  logic                 in_tlast,

	output logic                 out_tvalid,
	input  logic                 out_tready,
	output axis_pkg::axis_data_t out_tdata,
	output axis_pkg::axis_keep_t out_tkeep,
	output axis_pkg::axis_user_t out_tuser,
	output logic                 out_tlast
);
	import axis_pkg::*;

	// The skid entry catches the word that arrives while the main entry is stalled
	axis_data_t skid_tdata;
	axis_keep_t skid_tkeep;
	axis_user_t skid_tuser;
	logic       skid_tlast;
	logic       skid_valid;

	logic       in_fire;
	logic       main_load;
	logic       skid_valid_nxt;

	assign in_fire = in_tvalid && in_tready;

	// The main entry may take a new word when it is empty or being drained
	assign main_load = !out_tvalid || out_tready;

	// Ready is only high with the skid empty, so a full skid never sees an input word
	always_comb begin
		if (skid_valid) begin
			skid_valid_nxt = !main_load;
		end else begin
			skid_valid_nxt = in_fire && !main_load;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_tvalid <= 1'b0;
			skid_valid <= 1'b0;
			in_tready  <= 1'b0;
		end else begin
			skid_valid <= skid_valid_nxt;
			// Ready drops only once both entries hold a word
			in_tready  <= !skid_valid_nxt;
			if (main_load) begin
				out_tvalid <= skid_valid || in_fire;
			end
		end
	end

	// Payload moves from skid to main first so word order is kept
	always_ff @(posedge clk) begin
		if (main_load) begin
			if (skid_valid) begin
				out_tdata <= skid_tdata;
				out_tkeep <= skid_tkeep;
				out_tuser <= skid_tuser;
				out_tlast <= skid_tlast;
			end else begin
				out_tdata <= in_tdata;
				out_tkeep <= in_tkeep;
				out_tuser <= in_tuser;
				out_tlast <= in_tlast;
			end
		end else if (in_fire) begin
			skid_tdata <= in_tdata;
			skid_tkeep <= in_tkeep;
			skid_tuser <= in_tuser;
			skid_tlast <= in_tlast;
		end
	end

	// A stalled word must still be there with the same contents on the next edge
	a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
			$stable(out_tkeep) && $stable(out_tuser) && $stable(out_tlast))
		else $error("axis_register output changed while stalled");

endmodule

// ==== source/axis_pkg.sv ====
// Word types follow the widths in the defs header and the realigner FSM has three states only
`include "axis_defs.svh"

package axis_pkg;

	// One stream word of data
	typedef logic [8*`AXIS_BYTES-1:0] axis_data_t;

	// Byte enables with one bit per data lane
	typedef logic [`AXIS_BYTES-1:0] axis_keep_t;

	// Sideband carried along with each word
	typedef logic [`AXIS_USER_BITS-1:0] axis_user_t;

	// Index of the current word inside a packet
	// It saturates so that long packets keep counting as payload
	typedef logic [7:0] word_ctr_t;

	// RA_FIRST waits for the first word of a packet
	// RA_MID joins the stored residue with each new word
	// RA_FLUSH sends the last residue after tlast
	typedef enum logic [1:0] {
		RA_FIRST,
		RA_MID,
		RA_FLUSH
	} realign_state_t;

endpackage

// ==== source/axis_defs.svh ====
// Geometry is fixed at compile time and the split index must be at least one and stay below 256 words
`ifndef AXIS_DEFS_SVH
`define AXIS_DEFS_SVH

// Bytes carried by one stream word
// The data bus is eight times this many bits wide
`define AXIS_BYTES 4

// Width of the tuser sideband
// One tuser value covers a whole word, not a single byte
`define AXIS_USER_BITS 2

// Number of leading packet bytes that leave on the header stream
// Every byte at or after this index goes to the payload stream
// A value that is not a multiple of AXIS_BYTES leaves the payload unaligned
// until the realigner shifts it back down to lane 0
`define AXIS_SPLIT_INDEX 6

// Packets longer than 255 words are still passed on
// because the word counter saturates there and so stays on the payload side
// Only the split position must fall inside that range

`endif
